// File: rv_exec_unit.f
design/rv_exec_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_branch_unit.sv
design/rv_exec_output.sv
design/rv_exec_unit.sv
bench/rv_exec_unit_assertions.sv
bench/rv_exec_unit_tb.sv

// File: bench/rv_exec_unit_tb.sv
/* RV32I execute stage testbench */

`timescale 1ns/100ps

module rv_exec_unit_tb;

  logic                         clk;
  logic                         rst_n;
  logic                         in_valid;
  logic                         in_ready;
  logic [31:0]                  insn;
  logic [rv_exec_pkg::XLEN-1:0] pc;
  logic [rv_exec_pkg::XLEN-1:0] rs1;
  logic [rv_exec_pkg::XLEN-1:0] rs2;
  logic                         out_valid;
  logic                         out_ready;
  logic [rv_exec_pkg::XLEN-1:0] rd_data;
  logic [4:0]                   rd_addr;
  logic                         rd_we;
  logic [rv_exec_pkg::XLEN-1:0] next_pc;
  logic                         br_taken;
  logic                         illegal;

  integer      seed       = 32'h55ab;
  int          err_cnt    = 0;
  int          pass_cnt   = 0;
  int unsigned item_total = 168;   // 40 + 40 + 36 + 8 + 40 + 4
  logic        bp         = 1'b0;  // random out_ready when set
  string       test_name [6] = '{"op", "op_imm", "branch", "jump_upper", "backpressure",
                                 "illegal"};

  // items sent and not yet seen at the output
  logic [31:0] q_insn [$];
  logic [31:0] q_pc   [$];
  logic [31:0] q_rs1  [$];
  logic [31:0] q_rs2  [$];
  int          q_tid  [$];

  rv_exec_unit uut (
    .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .in_ready (in_ready),
    .insn (insn), .pc (pc), .rs1 (rs1), .rs2 (rs2), .out_valid (out_valid),
    .out_ready (out_ready), .rd_data (rd_data), .rd_addr (rd_addr), .rd_we (rd_we),
    .next_pc (next_pc), .br_taken (br_taken), .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rnd32();
    rnd32 = $random(seed);
  endfunction

  function automatic logic [4:0] rnd_rd();
    logic [31:0] r;
    r = $random(seed);
    rnd_rd = r[4:0];  // may be x0
  endfunction

  function automatic logic [31:0] rnd_pc();
    logic [31:0] r;
    r = $random(seed);
    rnd_pc = {r[31:2], 2'b00};  // word aligned
  endfunction

  // instruction word for the format of op, register fields are don't care
  function automatic logic [31:0] build_insn(input logic [6:0] op, input logic [2:0] f3,
                                             input logic f7_5, input logic [4:0] rd,
                                             input logic [31:0] imm);
    logic [11:0] imm_i;
    imm_i = imm[11:0];
    if (op == rv_exec_pkg::OPCODE_OP_IMM &&
        (f3 == rv_exec_pkg::F3_SL || f3 == rv_exec_pkg::F3_SR))
      imm_i = {1'b0, f7_5, 5'b0, imm[4:0]};  // shamt form
    case (op)
      rv_exec_pkg::OPCODE_OP     : build_insn = {1'b0, f7_5, 5'b0, 5'd2, 5'd1, f3, rd, op};
      rv_exec_pkg::OPCODE_BRANCH : build_insn = {imm[12], imm[10:5], 5'd2, 5'd1, f3,
                                                 imm[4:1], imm[11], op};
      rv_exec_pkg::OPCODE_JAL    : build_insn = {imm[20], imm[10:1], imm[11], imm[19:12],
                                                 rd, op};
      rv_exec_pkg::OPCODE_AUIPC,
      rv_exec_pkg::OPCODE_LUI    : build_insn = {imm[31:12], rd, op};
      default                    : build_insn = {imm_i, 5'd1, f3, rd, op};  // I-type
    endcase
  endfunction

  // called at edge + 10 ns, returns at edge + 10 ns after the transfer
  task automatic send_item(input int tid, input logic [31:0] w, input logic [31:0] p,
                           input logic [31:0] a, input logic [31:0] b);
    insn     = w;
    pc       = p;
    rs1      = a;
    rs2      = b;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) @(negedge clk);  // stalled by a full register
    q_insn.push_back(w);
    q_pc.push_back(p);
    q_rs1.push_back(a);
    q_rs2.push_back(b);
    q_tid.push_back(tid);
    @(posedge clk);
    #10;
  endtask

  task automatic finish_test(input int tid, input int n, input int err_before);
    in_valid = 1'b0;
    while (q_insn.size() != 0) begin  // drain
      @(posedge clk);
      #10;
    end
    $display("%-12s finished: %0d items, %0d errors", test_name[tid], n,
             err_cnt - err_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and compare
  ////////////////////////////////////////////////////////////////////////////

  function automatic void exp_result(input logic [31:0] w, input logic [31:0] p,
                                     input logic [31:0] a, input logic [31:0] b,
                                     output rv_exec_pkg::opc_t cls, output logic [31:0] data,
                                     output logic we, output logic [31:0] npc,
                                     output logic tkn);
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] opb;
    logic [4:0]  sh;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    imm_u = {w[31:12], 12'h000};
    cls   = rv_exec_pkg::OPC_ILLEGAL;
    data  = '0;
    npc   = p + 32'd4;  // sequential unless a jump or taken branch
    tkn   = 1'b0;
    case (w[6:0])
      rv_exec_pkg::OPCODE_OP,
      rv_exec_pkg::OPCODE_OP_IMM : begin
        cls = (w[6:0] == rv_exec_pkg::OPCODE_OP) ? rv_exec_pkg::OPC_OP : rv_exec_pkg::OPC_OP_IMM;
        opb = (cls == rv_exec_pkg::OPC_OP) ? b : imm_i;
        sh  = opb[4:0];
        case (w[14:12])
          rv_exec_pkg::F3_ADD  : data = (cls == rv_exec_pkg::OPC_OP && w[30]) ? a - opb : a + opb;
          rv_exec_pkg::F3_SL   : data = a << sh;
          rv_exec_pkg::F3_SLT  : data = {31'b0, $signed(a) < $signed(opb)};
          rv_exec_pkg::F3_SLTU : data = {31'b0, a < opb};
          rv_exec_pkg::F3_XOR  : data = a ^ opb;
          rv_exec_pkg::F3_OR   : data = a | opb;
          rv_exec_pkg::F3_SR   : begin
            if (w[30])
              data = $signed(a) >>> sh;  // sra / srai
            else
              data = a >> sh;
          end
          default              : data = a & opb;
        endcase
      end
      rv_exec_pkg::OPCODE_BRANCH : begin
        cls = rv_exec_pkg::OPC_BRANCH;
        case (w[14:12])
          rv_exec_pkg::BR_EQ  : tkn = (a == b);
          rv_exec_pkg::BR_NE  : tkn = (a != b);
          rv_exec_pkg::BR_LT  : tkn = ($signed(a) < $signed(b));
          rv_exec_pkg::BR_GE  : tkn = ($signed(a) >= $signed(b));
          rv_exec_pkg::BR_LTU : tkn = (a < b);
          rv_exec_pkg::BR_GEU : tkn = (a >= b);
          default             : tkn = 1'b0;
        endcase
        if (tkn)
          npc = p + imm_b;
      end
      rv_exec_pkg::OPCODE_JAL : begin
        cls  = rv_exec_pkg::OPC_JAL;
        data = p + 32'd4;
        npc  = p + imm_j;
      end
      rv_exec_pkg::OPCODE_JALR : begin
        cls  = rv_exec_pkg::OPC_JALR;
        data = p + 32'd4;
        npc  = (a + imm_i) & ~32'd1;
      end
      rv_exec_pkg::OPCODE_AUIPC : begin
        cls  = rv_exec_pkg::OPC_AUIPC;
        data = p + imm_u;
      end
      rv_exec_pkg::OPCODE_LUI : begin
        cls  = rv_exec_pkg::OPC_LUI;
        data = imm_u;
      end
      default : ;  // load, store, system, unknown
    endcase
    we = (cls != rv_exec_pkg::OPC_BRANCH) && (cls != rv_exec_pkg::OPC_ILLEGAL) &&
         (w[11:7] != 5'd0);
  endfunction

  task automatic check_word(input string name, input string what,
                            input logic [rv_exec_pkg::XLEN-1:0] exp,
                            input logic [rv_exec_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
      err_cnt++;
    end else
      pass_cnt++;
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b, actual %b", name, what, exp, act);
      err_cnt++;
    end else
      pass_cnt++;
  endtask

  task automatic check_opc_illegal(input string name, input rv_exec_pkg::opc_t cls,
                                   input logic act);
    logic exp;
    exp = (cls == rv_exec_pkg::OPC_ILLEGAL);
    if (act !== exp) begin
      $display("ERR %s illegal (class %0d): expected %b, actual %b", name, cls, exp, act);
      err_cnt++;
    end else
      pass_cnt++;
  endtask

  // values sampled mid cycle, the transfer follows at the next rising edge
  always @(negedge clk) begin : compare_results
    logic [31:0]       w;
    logic [31:0]       p;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       e_data;
    logic [31:0]       e_npc;
    logic              e_we;
    logic              e_tkn;
    rv_exec_pkg::opc_t cls;
    string             name;
    if (rst_n && out_valid && out_ready) begin
      if (q_insn.size() == 0) begin
        $display("output transfer seen with no item sent");
        err_cnt++;
      end else begin
        w    = q_insn.pop_front();
        p    = q_pc.pop_front();
        a    = q_rs1.pop_front();
        b    = q_rs2.pop_front();
        name = test_name[q_tid.pop_front()];
        exp_result(w, p, a, b, cls, e_data, e_we, e_npc, e_tkn);
        if (cls != rv_exec_pkg::OPC_BRANCH && cls != rv_exec_pkg::OPC_ILLEGAL)
          check_word(name, "rd_data", e_data, rd_data);  // no result defined otherwise
        check_word(name, "rd_addr", {27'b0, w[11:7]}, {27'b0, rd_addr});
        check_flag(name, "rd_we", e_we, rd_we);
        check_word(name, "next_pc", e_npc, next_pc);
        check_flag(name, "br_taken", e_tkn, br_taken);
        check_opc_illegal(name, cls, illegal);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sink, watchdog and tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin : sink_ready
    logic [31:0] r;
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #10;
      r         = $random(seed);
      out_ready = bp ? r[0] : 1'b1;
    end
  end

  initial begin : watchdog
    repeat (item_total * 4 + 50) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", item_total * 4 + 50);
    $display("Errors found");
    $finish;
  end

  initial begin : run_tests
    int                i;
    int                j;
    int                e0;
    logic [31:0]       r;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       imm;
    logic [2:0]        f3;
    logic              f7;
    logic [4:0]        rd;
    logic [6:0]        op;
    rv_exec_pkg::bru_t conds [6];
    logic [31:0]       pa [6];
    logic [31:0]       pb [6];
    logic [6:0]        ill_ops [4];
    conds   = '{rv_exec_pkg::BR_EQ, rv_exec_pkg::BR_NE, rv_exec_pkg::BR_LT,
                rv_exec_pkg::BR_GE, rv_exec_pkg::BR_LTU, rv_exec_pkg::BR_GEU};
    // equal, signed lt, signed gt, unsigned lt, unsigned gt, random
    pa      = '{32'd17, 32'hffff_fffb, 32'd3, 32'd3, 32'd7, 32'd0};
    pb      = '{32'd17, 32'd3, 32'hffff_fffb, 32'd7, 32'd3, 32'd0};
    ill_ops = '{rv_exec_pkg::OPCODE_LOAD, rv_exec_pkg::OPCODE_STORE,
                rv_exec_pkg::OPCODE_SYSTEM, 7'b1111111};
    insn     = '0;
    pc       = '0;
    rs1      = '0;
    rs2      = '0;
    in_valid = 1'b0;
    rst_n    = 1'b1;
    #1 rst_n = 1'b0;  // falling edge after time zero
    repeat (16) @(posedge clk);
    #10 rst_n = 1'b1;

    // register-register ops, sub and sra on odd passes
    e0 = err_cnt;
    for (i = 0; i < 40; i++) begin
      f3 = i[2:0];
      f7 = i[3] && (f3 == rv_exec_pkg::F3_ADD || f3 == rv_exec_pkg::F3_SR);
      send_item(0, build_insn(rv_exec_pkg::OPCODE_OP, f3, f7, rnd_rd(), 32'd0), rnd_pc(),
                rnd32(), rnd32());
    end
    finish_test(0, 40, e0);

    // immediate ops
    e0 = err_cnt;
    for (i = 0; i < 40; i++) begin
      f3    = i[2:0];
      f7    = i[3] && (f3 == rv_exec_pkg::F3_SR);
      a     = rnd32();
      a[31] = i[4];  // negative operand for srai
      r     = rnd32();
      imm   = {{20{r[11]}}, r[11:0]};
      send_item(1, build_insn(rv_exec_pkg::OPCODE_OP_IMM, f3, f7, rnd_rd(), imm), rnd_pc(),
                a, rnd32());
    end
    finish_test(1, 40, e0);

    // every condition against every operand pair
    e0 = err_cnt;
    for (i = 0; i < 6; i++) begin
      for (j = 0; j < 6; j++) begin
        a   = (j == 5) ? rnd32() : pa[j];
        b   = (j == 5) ? rnd32() : pb[j];
        r   = rnd32();
        imm = {{19{r[12]}}, r[12:1], 1'b0};
        send_item(2, build_insn(rv_exec_pkg::OPCODE_BRANCH, conds[i], 1'b0, rnd_rd(), imm),
                  rnd_pc(), a, b);
      end
    end
    finish_test(2, 36, e0);

    // jal, jalr, auipc, lui; second round with rd = x0
    e0 = err_cnt;
    for (i = 0; i < 8; i++) begin
      r  = rnd32();
      rd = (i < 4) ? (rnd_rd() | 5'd1) : 5'd0;
      a  = rnd32() | 32'd1;  // odd base, even imm
      case (i % 4)
        0 : begin
          op  = rv_exec_pkg::OPCODE_JAL;
          imm = {{11{r[20]}}, r[20:1], 1'b0};
        end
        1 : begin
          op  = rv_exec_pkg::OPCODE_JALR;
          imm = {{20{r[11]}}, r[11:1], 1'b0};
        end
        2 : begin
          op  = rv_exec_pkg::OPCODE_AUIPC;
          imm = {r[31:12], 12'h000};
        end
        default : begin
          op  = rv_exec_pkg::OPCODE_LUI;
          imm = {r[31:12], 12'h000};
        end
      endcase
      send_item(3, build_insn(op, 3'b000, 1'b0, rd, imm), rnd_pc(), a, rnd32());
    end
    finish_test(3, 8, e0);

    // random stalls at the output with in_valid held
    e0 = err_cnt;
    bp = 1'b1;
    for (i = 0; i < 40; i++) begin
      r  = rnd32();
      f3 = r[2:0];
      f7 = r[3] && (f3 == rv_exec_pkg::F3_ADD || f3 == rv_exec_pkg::F3_SR);
      op = i[0] ? rv_exec_pkg::OPCODE_OP : rv_exec_pkg::OPCODE_OP_IMM;
      send_item(4, build_insn(op, f3, f7, rnd_rd(), rnd32()), rnd_pc(), rnd32(), rnd32());
    end
    finish_test(4, 40, e0);
    bp = 1'b0;

    e0 = err_cnt;
    for (i = 0; i < 4; i++) begin
      r = rnd32();
      send_item(5, build_insn(ill_ops[i], r[2:0], 1'b0, rnd_rd(), rnd32()), rnd_pc(),
                rnd32(), rnd32());
    end
    finish_test(5, 4, e0);

    $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: bench/rv_exec_unit_assertions.sv
/* Execute stage handshake assertions */

`timescale 1ns/100ps

module rv_exec_unit_assertions (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         in_valid,
  input logic                         in_ready,
  input logic                         out_valid,
  input logic                         out_ready,
  input logic [rv_exec_pkg::XLEN-1:0] rd_data,
  input logic [rv_exec_pkg::XLEN-1:0] next_pc,
  input logic [4:0]                   rd_addr,
  input logic                         rd_we,
  input logic                         br_taken,
  input logic                         illegal
);

  // register empty and control flags cleared while in reset
  a_reset_empty : assert property (@(posedge clk)
    !rst_n |-> !out_valid && !rd_we && !br_taken && !illegal)
    else $error("outputs not cleared during reset");

  // stalled output holds every field
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(rd_data) && $stable(next_pc) &&
      $stable(rd_addr) && $stable(rd_we) && $stable(br_taken) && $stable(illegal))
    else $error("output changed while stalled");

  // one cycle latency
  a_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready |=> out_valid)
    else $error("no out_valid after input transfer");

endmodule

bind rv_exec_unit rv_exec_unit_assertions u_assert (.*);

// File: design/rv_exec_unit.sv
/* RV32I execute stage */

`timescale 1ns/100ps

module rv_exec_unit (
  input  logic                             clk,
  input  logic                             rst_n,
  // input side
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic [31:0]                      insn,
  input  logic [rv_exec_pkg::XLEN-1:0]     pc,
  input  logic [rv_exec_pkg::XLEN-1:0]     rs1,
  input  logic [rv_exec_pkg::XLEN-1:0]     rs2,
  // result side
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [rv_exec_pkg::XLEN-1:0]     rd_data,
  output logic [4:0]                       rd_addr,
  output logic                             rd_we,
  output logic [rv_exec_pkg::XLEN-1:0]     next_pc,
  output logic                             br_taken,
  output logic                             illegal
);

  // decode
  rv_exec_pkg::opc_t            opc;
  rv_exec_pkg::alu_f3_t         f3;
  rv_exec_pkg::bru_t            bru;
  logic                         f7_5;
  logic [rv_exec_pkg::XLEN-1:0] imm;
  logic [4:0]                   dec_rd_addr;
  logic                         dec_rd_we;
  // execute
  logic [rv_exec_pkg::XLEN-1:0] val;
  logic [rv_exec_pkg::XLEN:0]   sum;
  logic [rv_exec_pkg::XLEN-1:0] link;
  logic [rv_exec_pkg::XLEN-1:0] bru_next_pc;
  logic                         bru_taken;

  rv_decoder u_dec (
    .insn (insn), .opc (opc), .f3 (f3), .f7_5 (f7_5), .bru (bru), .imm (imm),
    .rd_addr (dec_rd_addr), .rd_we (dec_rd_we)
  );

  rv_alu u_alu (
    .opc (opc), .f3 (f3), .bru (bru), .f7_5 (f7_5), .pc (pc), .rs1 (rs1), .rs2 (rs2),
    .imm (imm), .val (val), .sum (sum)
  );

  rv_branch_unit u_bru (
    .opc (opc), .bru (bru), .sum (sum), .pc (pc), .imm (imm), .rs1 (rs1),
    .link (link), .next_pc (bru_next_pc), .br_taken (bru_taken)
  );

  // one cycle from input transfer to out_valid
  rv_exec_output u_out (
    .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .in_ready (in_ready),
    .opc (opc), .val (val), .link (link), .next_pc (bru_next_pc),
    .br_taken (bru_taken), .rd_addr (dec_rd_addr), .rd_we (dec_rd_we),
    .out_valid (out_valid), .out_ready (out_ready), .rd_data (rd_data),
    .next_pc_q (next_pc), .br_taken_q (br_taken), .rd_addr_q (rd_addr),
    .rd_we_q (rd_we), .illegal (illegal)
  );

endmodule

// File: design/rv_exec_output.sv
/* Execute stage output register */

`timescale 1ns/100ps

module rv_exec_output (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  rv_exec_pkg::opc_t                opc,
  input  logic [rv_exec_pkg::XLEN-1:0]     val,
  input  logic [rv_exec_pkg::XLEN-1:0]     link,
  input  logic [rv_exec_pkg::XLEN-1:0]     next_pc,
  input  logic                             br_taken,
  input  logic [4:0]                       rd_addr,
  input  logic                             rd_we,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [rv_exec_pkg::XLEN-1:0]     rd_data,
  output logic [rv_exec_pkg::XLEN-1:0]     next_pc_q,
  output logic                             br_taken_q,
  output logic [4:0]                       rd_addr_q,
  output logic                             rd_we_q,
  output logic                             illegal
);

  logic is_ill;   // unsupported opcode
  logic is_jmp;   // jal/jalr write the link
  logic xfer_in;  // input transfer this edge

  assign is_ill  = (opc == rv_exec_pkg::OPC_ILLEGAL);
  assign is_jmp  = (opc == rv_exec_pkg::OPC_JAL) || (opc == rv_exec_pkg::OPC_JALR);

  // empty, or drained in this same cycle
  assign in_ready = !out_valid || out_ready;
  assign xfer_in  = in_valid && in_ready;

  // control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      rd_we_q    <= 1'b0;
      br_taken_q <= 1'b0;
      illegal    <= 1'b0;
    end else if (xfer_in) begin
      out_valid  <= 1'b1;
      rd_we_q    <= rd_we && !is_ill;  // never write on illegal
      br_taken_q <= br_taken;
      illegal    <= is_ill;
    end else if (out_ready) begin
      out_valid  <= 1'b0;              // drained, nothing new
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (xfer_in) begin
      rd_data   <= is_jmp ? link : val;
      next_pc_q <= next_pc;
      rd_addr_q <= rd_addr;
    end
  end

endmodule

// File: design/rv_branch_unit.sv
/* Branch and jump unit */

`timescale 1ns/100ps

module rv_branch_unit (
  input  rv_exec_pkg::opc_t                opc,
  input  rv_exec_pkg::bru_t                bru,
  input  logic [rv_exec_pkg::XLEN:0]       sum,      // rs1 - rs2 from the alu
  input  logic [rv_exec_pkg::XLEN-1:0]     pc,
  input  logic [rv_exec_pkg::XLEN-1:0]     imm,
  input  logic [rv_exec_pkg::XLEN-1:0]     rs1,
  output logic [rv_exec_pkg::XLEN-1:0]     link,     // return address
  output logic [rv_exec_pkg::XLEN-1:0]     next_pc,
  output logic                             br_taken  // conditional branches only
);

  logic                         cmp_eq;    // operands equal
  logic                         cmp_lt;    // rs1 < rs2, signedness from alu
  logic                         cond;      // condition met
  logic [rv_exec_pkg::XLEN-1:0] pc_tgt;    // pc relative target
  logic [rv_exec_pkg::XLEN-1:0] jalr_sum;  // register relative target

  ////////////////////////////////////////////////////////////////////////////
  // condition
  ////////////////////////////////////////////////////////////////////////////

  assign cmp_eq = (sum[rv_exec_pkg::XLEN-1:0] == '0);
  assign cmp_lt = sum[rv_exec_pkg::XLEN];

  always_comb begin
    case (bru)
      rv_exec_pkg::BR_EQ  : cond = cmp_eq;
      rv_exec_pkg::BR_NE  : cond = !cmp_eq;
      rv_exec_pkg::BR_LT,
      rv_exec_pkg::BR_LTU : cond = cmp_lt;
      rv_exec_pkg::BR_GE,
      rv_exec_pkg::BR_GEU : cond = !cmp_lt;
      default             : cond = 1'b0;  // reserved funct3 never taken
    endcase
  end

  assign br_taken = (opc == rv_exec_pkg::OPC_BRANCH) && cond;

  // targets
  assign link     = pc + 32'd4;
  assign pc_tgt   = pc + imm;        // branch and jal
  assign jalr_sum = rs1 + imm;

  always_comb begin
    case (opc)
      rv_exec_pkg::OPC_BRANCH : next_pc = br_taken ? pc_tgt : link;
      rv_exec_pkg::OPC_JAL    : next_pc = pc_tgt;
      rv_exec_pkg::OPC_JALR   : next_pc = {jalr_sum[rv_exec_pkg::XLEN-1:1], 1'b0};  // lsb cleared
      default                 : next_pc = link;  // sequential
    endcase
  end

endmodule

// File: design/rv_alu.sv
/* RV32I arithmetic/logic unit */

`timescale 1ns/100ps

module rv_alu (
  input  rv_exec_pkg::opc_t                opc,
  input  rv_exec_pkg::alu_f3_t             f3,
  input  rv_exec_pkg::bru_t                bru,
  input  logic                             f7_5,
  input  logic [rv_exec_pkg::XLEN-1:0]     pc,
  input  logic [rv_exec_pkg::XLEN-1:0]     rs1,
  input  logic [rv_exec_pkg::XLEN-1:0]     rs2,
  input  logic [rv_exec_pkg::XLEN-1:0]     imm,
  output logic [rv_exec_pkg::XLEN-1:0]     val,    // operation result
  output logic [rv_exec_pkg::XLEN:0]       sum     // adder result plus top bit
);

  logic [rv_exec_pkg::XLEN-1:0] op1;      // operand 1
  logic [rv_exec_pkg::XLEN-1:0] op2;      // operand 2
  logic [rv_exec_pkg::XLEN:0]   add_op1;  // extended by one bit
  logic [rv_exec_pkg::XLEN:0]   add_op2;
  logic                         add_inv;  // subtract
  logic                         add_sgn;  // signed extension
  logic [rv_exec_pkg::XLOG-1:0] shf_sam;  // shift amount
  logic [rv_exec_pkg::XLEN-1:0] shf_tmp;  // shifter input, reversed for left
  logic [rv_exec_pkg::XLEN-1:0] shf_val;  // shifter output
  logic                         shf_ari;  // arithmetic right shift

  // bit order reversal
  function automatic logic [rv_exec_pkg::XLEN-1:0] bitrev(
    input logic [rv_exec_pkg::XLEN-1:0] v
  );
    for (int i = 0; i < rv_exec_pkg::XLEN; i++) begin
      bitrev[i] = v[rv_exec_pkg::XLEN-1-i];
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // operands and adder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opc)
      rv_exec_pkg::OPC_AUIPC,
      rv_exec_pkg::OPC_JAL : op1 = pc;
      rv_exec_pkg::OPC_LUI : op1 = '0;  // sum passes imm through
      default              : op1 = rs1;
    endcase
    if (opc == rv_exec_pkg::OPC_OP || opc == rv_exec_pkg::OPC_BRANCH)
      op2 = rs2;
    else
      op2 = imm;
  end

  // invert and signedness per operation
  always_comb begin
    add_inv = 1'b0;
    add_sgn = 1'b1;
    case (opc)
      rv_exec_pkg::OPC_OP,
      rv_exec_pkg::OPC_OP_IMM : begin
        case (f3)
          rv_exec_pkg::F3_ADD  : add_inv = f7_5;  // f7_5 already 0 for addi
          rv_exec_pkg::F3_SLT  : add_inv = 1'b1;
          rv_exec_pkg::F3_SLTU : begin
            add_inv = 1'b1;
            add_sgn = 1'b0;
          end
          default              : add_inv = 1'b0;
        endcase
      end
      rv_exec_pkg::OPC_BRANCH : begin
        add_inv = 1'b1;                       // compare is rs1 - rs2
        add_sgn = (bru != rv_exec_pkg::BR_LTU) && (bru != rv_exec_pkg::BR_GEU);
      end
      default : add_inv = 1'b0;               // plain add for addresses
    endcase
  end

  assign add_op1 = {add_sgn & op1[rv_exec_pkg::XLEN-1], op1};
  assign add_op2 = {add_sgn & op2[rv_exec_pkg::XLEN-1], op2};

  // top bit is the less-than result when subtracting
  assign sum = add_op1 + (add_inv ? ~add_op2 : add_op2)
             + {{rv_exec_pkg::XLEN{1'b0}}, add_inv};

  ////////////////////////////////////////////////////////////////////////////
  // barrel shifter
  ////////////////////////////////////////////////////////////////////////////

  assign shf_sam = op2[rv_exec_pkg::XLOG-1:0];      // rs2 or shamt
  assign shf_tmp = (f3 == rv_exec_pkg::F3_SL) ? bitrev(rs1) : rs1;
  assign shf_ari = f7_5 & (f3 == rv_exec_pkg::F3_SR);

  // kept as two branches so the signed shift stays signed
  always_comb begin
    if (shf_ari)
      shf_val = $signed(shf_tmp) >>> shf_sam;
    else
      shf_val = shf_tmp >> shf_sam;
  end

  // result select
  always_comb begin
    case (opc)
      rv_exec_pkg::OPC_OP,
      rv_exec_pkg::OPC_OP_IMM : begin
        case (f3)
          rv_exec_pkg::F3_ADD  : val = sum[rv_exec_pkg::XLEN-1:0];
          rv_exec_pkg::F3_SLT,
          rv_exec_pkg::F3_SLTU : val = {{(rv_exec_pkg::XLEN-1){1'b0}}, sum[rv_exec_pkg::XLEN]};
          rv_exec_pkg::F3_XOR  : val = op1 ^ op2;
          rv_exec_pkg::F3_OR   : val = op1 | op2;
          rv_exec_pkg::F3_AND  : val = op1 & op2;
          rv_exec_pkg::F3_SR   : val = shf_val;
          default              : val = bitrev(shf_val);  // shift left
        endcase
      end
      rv_exec_pkg::OPC_AUIPC,
      rv_exec_pkg::OPC_LUI    : val = sum[rv_exec_pkg::XLEN-1:0];
      default                 : val = '0;  // jumps use link, branches write nothing
    endcase
  end

endmodule

// File: design/rv_decoder.sv
/* RV32I instruction decoder */

`timescale 1ns/100ps

module rv_decoder (
  input  logic [31:0]                      insn,     // instruction word
  output rv_exec_pkg::opc_t                opc,      // opcode class
  output rv_exec_pkg::alu_f3_t             f3,       // alu operation
  output logic                             f7_5,     // sub / arithmetic shift
  output rv_exec_pkg::bru_t                bru,      // branch condition
  output logic [rv_exec_pkg::XLEN-1:0]     imm,      // sign extended immediate
  output logic [4:0]                       rd_addr,
  output logic                             rd_we
);

  // immediates of each format
  logic [rv_exec_pkg::XLEN-1:0] imm_i;
  logic [rv_exec_pkg::XLEN-1:0] imm_b;
  logic [rv_exec_pkg::XLEN-1:0] imm_j;
  logic [rv_exec_pkg::XLEN-1:0] imm_u;

  ////////////////////////////////////////////////////////////////////////////
  // opcode class
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (insn[6:0])
      rv_exec_pkg::OPCODE_OP     : opc = rv_exec_pkg::OPC_OP;
      rv_exec_pkg::OPCODE_OP_IMM : opc = rv_exec_pkg::OPC_OP_IMM;
      rv_exec_pkg::OPCODE_BRANCH : opc = rv_exec_pkg::OPC_BRANCH;
      rv_exec_pkg::OPCODE_JAL    : opc = rv_exec_pkg::OPC_JAL;
      rv_exec_pkg::OPCODE_JALR   : opc = rv_exec_pkg::OPC_JALR;
      rv_exec_pkg::OPCODE_AUIPC  : opc = rv_exec_pkg::OPC_AUIPC;
      rv_exec_pkg::OPCODE_LUI    : opc = rv_exec_pkg::OPC_LUI;
      // no memory port and no csr here
      rv_exec_pkg::OPCODE_LOAD,
      rv_exec_pkg::OPCODE_STORE,
      rv_exec_pkg::OPCODE_SYSTEM : opc = rv_exec_pkg::OPC_ILLEGAL;
      default                    : opc = rv_exec_pkg::OPC_ILLEGAL;
    endcase
  end

  // function fields
  assign f3  = rv_exec_pkg::alu_f3_t'(insn[14:12]);
  assign bru = rv_exec_pkg::bru_t'(insn[14:12]);

  // bit 30 only matters for OP, and for OP_IMM right shifts
  always_comb begin
    case (opc)
      rv_exec_pkg::OPC_OP     : f7_5 = insn[30];
      rv_exec_pkg::OPC_OP_IMM : f7_5 = insn[30] & (f3 == rv_exec_pkg::F3_SR);  // addi never subs
      default                 : f7_5 = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // immediates
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i = {{(rv_exec_pkg::XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(rv_exec_pkg::XLEN-13){insn[31]}}, insn[31], insn[7],
                  insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{(rv_exec_pkg::XLEN-21){insn[31]}}, insn[31], insn[19:12],
                  insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};  // 32 bit only

  always_comb begin
    case (opc)
      rv_exec_pkg::OPC_OP_IMM,
      rv_exec_pkg::OPC_JALR   : imm = imm_i;
      rv_exec_pkg::OPC_BRANCH : imm = imm_b;
      rv_exec_pkg::OPC_JAL    : imm = imm_j;
      rv_exec_pkg::OPC_AUIPC,
      rv_exec_pkg::OPC_LUI    : imm = imm_u;
      default                 : imm = '0;  // R-type has none
    endcase
  end

  // destination
  assign rd_addr = insn[11:7];

  always_comb begin
    case (opc)
      rv_exec_pkg::OPC_BRANCH,
      rv_exec_pkg::OPC_ILLEGAL : rd_we = 1'b0;
      default                  : rd_we = (rd_addr != 5'd0);  // x0 never written
    endcase
  end

endmodule

// File: design/rv_exec_pkg.sv
/* RV32I execute stage definitions */

package rv_exec_pkg;

  // data width and shift amount width
  localparam int unsigned XLEN = 32;
  localparam int unsigned XLOG = 5;

  ////////////////////////////////////////////////////////////////////////////
  // major opcodes (insn[6:0])
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  // opcode classes handled by the stage
  typedef enum logic [2:0] {
    OPC_OP      = 3'd0,
    OPC_OP_IMM  = 3'd1,
    OPC_BRANCH  = 3'd2,
    OPC_JAL     = 3'd3,
    OPC_JALR    = 3'd4,
    OPC_AUIPC   = 3'd5,
    OPC_LUI     = 3'd6,
    OPC_ILLEGAL = 3'd7   // load/store/system/unknown
  } opc_t;

  // arithmetic/logic funct3
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,  // add/sub
    F3_SL   = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,  // srl/sra
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_t;

  // branch funct3 (01x unused)
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } bru_t;

endpackage
